// File: list.f
+incdir+common
common/jpeg_pkg.sv
common/ycc_pair_if.sv
jisp/rgb_to_ycc.sv
jisp/jisp.sv
jenc/jenc.sv
src/jpeg_capture_ctrl.sv
src/jpeg_encoder.sv
verification/jpeg_encoder_props.sv
verification/tb_jpeg_encoder.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_jpeg_encoder \
    -f list.f -o tb_jpeg_encoder_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_jpeg_encoder_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: verification/tb_jpeg_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the capture front end
// checking is done by the bound assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "jpeg_cfg.svh"

module tb_jpeg_encoder;

    localparam int XW = `JPEG_X_SIZE_W;
    localparam int YW = `JPEG_Y_SIZE_W;
    localparam int WATCHDOG_CYCLES = 4 * (7 * (8 * 4 + 50) + (6 * 3 + 50));

    logic          clk;
    logic          rst_n;
    logic          start;
    logic [9:0]    red;
    logic [9:0]    green;
    logic [9:0]    blue;
    logic          fv;
    logic          lv;
    logic [1:0]    qf;
    logic [XW-1:0] xs;
    logic [YW-1:0] ys;
    logic [31:0]   data_out;
    logic [15:0]   address_out;
    logic          image_valid_out;
    logic          data_valid_out;
    logic [127:0]  test_name;

    logic           stim_valid;   // second pixel of a captured pair is on the inputs
    logic [31:0]    stim_data;
    logic [15:0]    stim_addr;
    logic           stim_last;
    logic [4:0]     exp_valid_sr = '0;
    logic [31:0]    exp_data_sr [5];
    logic [15:0]    exp_addr_sr [5];
    logic [4:0]     exp_last_sr = '0;
    logic           exp_valid;
    logic [31:0]    exp_data;
    logic [15:0]    exp_addr;
    logic           exp_last;
    int             word_idx;
    jpeg_pkg::ycc_t first_pix;

    jpeg_encoder i_jpeg_encoder (
        .pixel_clock_in       (clk),
        .jpeg_fast_reset_n_in (rst_n),
        .start_capture_in     (start),
        .red_data_in          (red),
        .green_data_in        (green),
        .blue_data_in         (blue),
        .frame_valid_in       (fv),
        .line_valid_in        (lv),
        .qf_select_in         (qf),
        .x_size_in            (xs),
        .y_size_in            (ys),
        .data_out             (data_out),
        .address_out          (address_out),
        .image_valid_out      (image_valid_out),
        .data_valid_out       (data_valid_out)
    );

    bind jpeg_encoder jpeg_encoder_props i_props (
        .pixel_clock_in       (pixel_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .start_capture_in     (start_capture_in),
        .data_out             (data_out),
        .address_out          (address_out),
        .image_valid_out      (image_valid_out),
        .data_valid_out       (data_valid_out),
        .state                (i_jpeg_capture_ctrl.state),
        .exp_valid            (tb_jpeg_encoder.exp_valid),
        .exp_data             (tb_jpeg_encoder.exp_data),
        .exp_addr             (tb_jpeg_encoder.exp_addr),
        .exp_last             (tb_jpeg_encoder.exp_last),
        .test_name            (tb_jpeg_encoder.test_name)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model latency line, 5 cycles like the DUT
    always @(posedge clk) begin
        exp_valid_sr <= {exp_valid_sr[3:0], stim_valid};
        exp_last_sr  <= {exp_last_sr[3:0], stim_valid & stim_last};
        exp_data_sr[0] <= stim_data;
        exp_addr_sr[0] <= stim_addr;
        for (int i = 1; i < 5; i++) begin
            exp_data_sr[i] <= exp_data_sr[i-1];
            exp_addr_sr[i] <= exp_addr_sr[i-1];
        end
    end

    assign exp_valid = exp_valid_sr[4];
    assign exp_last  = exp_last_sr[4];
    assign exp_data  = exp_data_sr[4];
    assign exp_addr  = exp_addr_sr[4];

    always @(negedge clk) begin
        if (i_jpeg_encoder.i_props.err_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failed in %0s", test_name);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [7:0] clamp_byte(input int v);
        if (v < 0)
            return 8'd0;
        if (v > 255)
            return 8'd255;
        return v[7:0];
    endfunction

    // bt.601 style conversion with 8 fractional bits
    function automatic jpeg_pkg::ycc_t convert_pixel(input jpeg_pkg::rgb24_t p);
        int r;
        int g;
        int b;
        jpeg_pkg::ycc_t c;
        r = int'(p.red);
        g = int'(p.green);
        b = int'(p.blue);
        c.y  = clamp_byte((77 * r + 150 * g + 29 * b) >>> 8);
        c.cb = clamp_byte(((-43 * r - 85 * g + 128 * b) >>> 8) + 128);
        c.cr = clamp_byte(((128 * r - 107 * g - 21 * b) >>> 8) + 128);
        return c;
    endfunction

    // quantize and store little-endian, y0 in the low byte
    function automatic logic [31:0] expected_word(input jpeg_pkg::ycc_t a,
                                                  input jpeg_pkg::ycc_t b,
                                                  input logic [1:0] q);
        int ls;
        int cs;
        ls = int'(q);
        cs = int'(q) + 1;
        return {a.cr >> cs, a.cb >> cs, b.y >> ls, a.y >> ls};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        stim_valid = 1'b0;
    endtask

    task automatic drive_frame(input int w, input int h, input bit capture);
        jpeg_pkg::rgb24_t p;
        jpeg_pkg::ycc_t   c;
        fv = 1'b1;
        next_cycle();
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                next_cycle();
                if (x == w / 2 && y % 2 == 1) begin
                    lv = 1'b0;               // short gap inside the line
                    next_cycle();
                end
                lv    = 1'b1;
                red   = 10'($urandom);
                green = 10'($urandom);
                blue  = 10'($urandom);
                p = '{red: red[9:2], green: green[9:2], blue: blue[9:2]};
                if (capture) begin
                    c = convert_pixel(p);
                    if (x % 2 == 0) begin
                        first_pix = c;
                    end else begin
                        stim_valid = 1'b1;
                        stim_data  = expected_word(first_pix, c, qf);
                        stim_addr  = 16'(word_idx * 4);
                        stim_last  = (x == w - 1) && (y == h - 1);
                        word_idx++;
                    end
                end
            end
            next_cycle();
            lv = 1'b0;
            repeat (2) next_cycle();
        end
        fv = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_image_valid();
        while (!image_valid_out)
            next_cycle();
        repeat (4) next_cycle();
    endtask

    task automatic capture_frame(input logic [1:0] q, input int w, input int h);
        qf = q;
        xs = XW'(w);
        ys = YW'(h);
        pulse_start();
        repeat (3) next_cycle();
        word_idx = 0;
        drive_frame(w, h, 1'b1);
        wait_image_valid();
    endtask

    initial begin
        void'($urandom(32'h2c9b));
        rst_n      = 1'b0;
        start      = 1'b0;
        red        = '0;
        green      = '0;
        blue       = '0;
        fv         = 1'b0;
        lv         = 1'b0;
        qf         = 2'd0;
        xs         = XW'(8);
        ys         = YW'(4);
        stim_valid = 1'b0;
        stim_data  = '0;
        stim_addr  = '0;
        stim_last  = 1'b0;
        word_idx   = 0;
        test_name  = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        test_name = "no_start";
        drive_frame(8, 4, 1'b0);

        // start while a frame runs, that frame must be dropped
        test_name = "skip_running";
        fv = 1'b1;
        next_cycle();
        pulse_start();
        drive_frame(8, 4, 1'b0);
        test_name = "capture_q0";
        word_idx = 0;
        drive_frame(8, 4, 1'b1);
        wait_image_valid();

        test_name = "hold_image";
        drive_frame(8, 4, 1'b0);

        test_name = "capture_q1";
        capture_frame(2'd1, 8, 4);
        test_name = "capture_q2";
        capture_frame(2'd2, 8, 4);
        test_name = "capture_q3";
        capture_frame(2'd3, 8, 4);

        test_name = "resize_6x3";
        capture_frame(2'd2, 6, 3);

        repeat (10) next_cycle();
        if (i_jpeg_encoder.i_props.err_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failures found");
        end
    end

endmodule

// File: verification/jpeg_encoder_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checker bound into jpeg_encoder
// expected words come from the testbench model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jpeg_encoder_props (
    input logic                     pixel_clock_in,
    input logic                     jpeg_fast_reset_n_in,
    input logic                     start_capture_in,
    input logic [31:0]              data_out,
    input logic [15:0]              address_out,
    input logic                     image_valid_out,
    input logic                     data_valid_out,
    input jpeg_pkg::capture_state_t state,
    input logic                     exp_valid,
    input logic [31:0]              exp_data,
    input logic [15:0]              exp_addr,
    input logic                     exp_last,
    input logic [127:0]             test_name
);

    int err_count = 0;   // read by the testbench

    // word strobe lands exactly 5 cycles after the second pixel
    a_valid_timing: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        data_valid_out == exp_valid)
        else begin
            err_count++;
            $error("ERR %0s expected %b actual %b", test_name, exp_valid, data_valid_out);
        end

    a_data: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        data_valid_out |-> data_out == exp_data)
        else begin
            err_count++;
            $error("ERR %0s expected %h actual %h", test_name, exp_data, data_out);
        end

    a_addr: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        data_valid_out |-> address_out == exp_addr)
        else begin
            err_count++;
            $error("ERR %0s expected %h actual %h", test_name, exp_addr, address_out);
        end

    a_spacing: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        data_valid_out |=> !data_valid_out)
        else begin
            err_count++;
            $error("%0s: data_valid_out was high in two consecutive cycles", test_name);
        end

    // image valid rises together with the final word of the frame
    a_image_rise: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        $rose(image_valid_out) |-> data_valid_out && exp_last)
        else begin
            err_count++;
            $error("%0s: image_valid_out rose without the final word", test_name);
        end

    a_last_word: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        data_valid_out && exp_last |-> image_valid_out)
        else begin
            err_count++;
            $error("%0s: final word arrived without image_valid_out", test_name);
        end

    a_image_hold: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        image_valid_out && !start_capture_in |=> image_valid_out)
        else begin
            err_count++;
            $error("%0s: image_valid_out fell before a new start", test_name);
        end

    a_quiet_after: assert property (@(posedge pixel_clock_in)
        disable iff (!jpeg_fast_reset_n_in)
        image_valid_out && !$rose(image_valid_out) |-> !data_valid_out)
        else begin
            err_count++;
            $error("%0s: a word arrived while the image was already valid", test_name);
        end

    a_reset: assert property (@(posedge pixel_clock_in)
        !jpeg_fast_reset_n_in |=> state == jpeg_pkg::IDLE && !data_valid_out &&
                                  !image_valid_out)
        else begin
            err_count++;
            $error("%0s: outputs or state not cleared by reset", test_name);
        end

endmodule

// File: src/jpeg_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// jpeg capture front end, single clock
// 5 cycles from second pixel of a pair to data
// frame width must be even
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "jpeg_cfg.svh"

module jpeg_encoder (
    input  logic                      pixel_clock_in,
    input  logic                      jpeg_fast_reset_n_in,
    input  logic                      start_capture_in,
    input  logic [9:0]                red_data_in,
    input  logic [9:0]                green_data_in,
    input  logic [9:0]                blue_data_in,
    input  logic                      frame_valid_in,
    input  logic                      line_valid_in,
    input  logic [1:0]                qf_select_in,
    input  logic [`JPEG_X_SIZE_W-1:0] x_size_in,
    input  logic [`JPEG_Y_SIZE_W-1:0] y_size_in,
    output logic [31:0]               data_out,       // byte-swapped pair
    output logic [15:0]               address_out,    // byte address of data_out
    output logic                      image_valid_out,
    output logic                      data_valid_out
);

    logic        pipe_en;
    logic        pipe_reset_n;
    logic [31:0] word;
    logic        word_valid;
    logic        word_last;

    ycc_pair_if pair_bus ();

    jpeg_capture_ctrl i_jpeg_capture_ctrl (
        .pixel_clock_in       (pixel_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .start_capture_in     (start_capture_in),
        .frame_valid_in       (frame_valid_in),
        .word                 (word),
        .word_valid           (word_valid),
        .word_last            (word_last),
        .pipe_en              (pipe_en),
        .pipe_reset_n         (pipe_reset_n),
        .data_out             (data_out),
        .address_out          (address_out),
        .image_valid_out      (image_valid_out),
        .data_valid_out       (data_valid_out)
    );

    jisp i_jisp (
        .pixel_clock_in (pixel_clock_in),
        .pipe_reset_n   (pipe_reset_n),
        .pipe_en        (pipe_en),
        .red_data_in    (red_data_in),
        .green_data_in  (green_data_in),
        .blue_data_in   (blue_data_in),
        .frame_valid_in (frame_valid_in),
        .line_valid_in  (line_valid_in),
        .x_size_in      (x_size_in),
        .y_size_in      (y_size_in),
        .pair           (pair_bus.src)
    );

    jenc i_jenc (
        .pixel_clock_in (pixel_clock_in),
        .pipe_reset_n   (pipe_reset_n),
        .qf_select      (qf_select_in),
        .pair           (pair_bus.dst),
        .word           (word),
        .word_valid     (word_valid),
        .word_last      (word_last)
    );

endmodule

// File: src/jpeg_capture_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// capture fsm and output stage
// a frame already running at start is skipped
// words arrive at most every other cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jpeg_capture_ctrl (
    input  logic        pixel_clock_in,
    input  logic        jpeg_fast_reset_n_in,
    input  logic        start_capture_in,
    input  logic        frame_valid_in,
    input  logic [31:0] word,
    input  logic        word_valid,
    input  logic        word_last,
    output logic        pipe_en,
    output logic        pipe_reset_n,
    output logic [31:0] data_out,
    output logic [15:0] address_out,
    output logic        image_valid_out,
    output logic        data_valid_out
);

    jpeg_pkg::capture_state_t state;
    jpeg_pkg::capture_state_t state_next;
    logic [19:0]              byte_cnt;   // running byte address

    always_comb begin
        state_next = state;
        case (state)
            jpeg_pkg::RESET: begin
                if (!frame_valid_in)     // let the current frame finish
                    state_next = jpeg_pkg::WAIT_FOR_FRAME_START;
            end
            jpeg_pkg::WAIT_FOR_FRAME_START: begin
                if (frame_valid_in)
                    state_next = jpeg_pkg::COMPRESS;
            end
            jpeg_pkg::COMPRESS: begin
                if (word_valid && word_last)
                    state_next = jpeg_pkg::IMAGE_VALID;
            end
            default: begin                // idle or image valid
                if (start_capture_in)
                    state_next = jpeg_pkg::RESET;
            end
        endcase
    end

    always_ff @(posedge pixel_clock_in) begin
        if (!jpeg_fast_reset_n_in) begin
            state          <= jpeg_pkg::IDLE;
            pipe_reset_n   <= 1'b0;   // pipeline held clear during global reset
            byte_cnt       <= '0;
            data_valid_out <= 1'b0;
        end else begin
            state          <= state_next;
            pipe_reset_n   <= state_next != jpeg_pkg::RESET;
            data_valid_out <= word_valid;
            if (state == jpeg_pkg::WAIT_FOR_FRAME_START && frame_valid_in)
                byte_cnt <= '0;
            else if (word_valid)
                byte_cnt <= byte_cnt + 20'd4;
        end
    end

    // byte swap so memory sees y0 at the lowest address
    always_ff @(posedge pixel_clock_in) begin
        if (word_valid) begin
            for (int i = 0; i < 4; i++)
                data_out[8*i +: 8] <= word[8*(3-i) +: 8];
            address_out <= byte_cnt[15:0];
        end
    end

    assign pipe_en = (state == jpeg_pkg::WAIT_FOR_FRAME_START) ||
                     (state == jpeg_pkg::COMPRESS);
    assign image_valid_out = state == jpeg_pkg::IMAGE_VALID;

endmodule

// File: jenc/jenc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shift quantizer and word packer
// word is big-endian, y0 in the top byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "jpeg_cfg.svh"

module jenc (
    input  logic        pixel_clock_in,
    input  logic        pipe_reset_n,
    input  logic [1:0]  qf_select,
    ycc_pair_if.dst     pair,
    output logic [31:0] word,
    output logic        word_valid,
    output logic        word_last
);

    logic [2:0]  luma_shift;
    logic [2:0]  chroma_shift;
    logic [31:0] packed_word;

    // lower quality drops more low-order bits
    always_comb begin
        case (qf_select)
            2'd0: begin
                luma_shift   = `JPEG_LUMA_SHIFT_0;
                chroma_shift = `JPEG_CHROMA_SHIFT_0;
            end
            2'd1: begin
                luma_shift   = `JPEG_LUMA_SHIFT_1;
                chroma_shift = `JPEG_CHROMA_SHIFT_1;
            end
            2'd2: begin
                luma_shift   = `JPEG_LUMA_SHIFT_2;
                chroma_shift = `JPEG_CHROMA_SHIFT_2;
            end
            default: begin
                luma_shift   = `JPEG_LUMA_SHIFT_3;
                chroma_shift = `JPEG_CHROMA_SHIFT_3;
            end
        endcase
    end

    assign packed_word = {pair.y0 >> luma_shift,
                          pair.y1 >> luma_shift,
                          pair.cb >> chroma_shift,
                          pair.cr >> chroma_shift};

    always_ff @(posedge pixel_clock_in) begin
        if (!pipe_reset_n) begin
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            word_valid <= pair.valid;
            word_last  <= pair.valid & pair.last;
        end
    end

    always_ff @(posedge pixel_clock_in) begin
        if (pair.valid)
            word <= packed_word;
    end

endmodule

// File: jisp/jisp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel gating, position count and 4:2:2 pairing
// x_size_in must be even and at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "jpeg_cfg.svh"

module jisp (
    input  logic                      pixel_clock_in,
    input  logic                      pipe_reset_n,
    input  logic                      pipe_en,
    input  logic [9:0]                red_data_in,
    input  logic [9:0]                green_data_in,
    input  logic [9:0]                blue_data_in,
    input  logic                      frame_valid_in,
    input  logic                      line_valid_in,
    input  logic [`JPEG_X_SIZE_W-1:0] x_size_in,
    input  logic [`JPEG_Y_SIZE_W-1:0] y_size_in,
    ycc_pair_if.src                   pair
);

    localparam int XW = `JPEG_X_SIZE_W;
    localparam int YW = `JPEG_Y_SIZE_W;

    logic             accept;
    logic [XW-1:0]    x_cnt;
    logic [YW-1:0]    y_cnt;
    logic             x_end;
    logic             y_end;
    jpeg_pkg::rgb24_t pix_rgb;
    logic             pix_valid;
    logic             pix_odd;
    logic             pix_last;
    logic [1:0]       odd_dly;     // tags follow the 2 cycle converter
    logic [1:0]       last_dly;
    jpeg_pkg::ycc_t   ycc;
    logic             ycc_valid;
    jpeg_pkg::ycc_t   first_q;     // even pixel waiting for its partner

    assign accept = pipe_en & frame_valid_in & line_valid_in;
    assign x_end  = x_cnt == x_size_in - XW'(1);
    assign y_end  = y_cnt == y_size_in - YW'(1);

    always_ff @(posedge pixel_clock_in) begin
        if (!pipe_reset_n || !frame_valid_in) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (accept) begin
            x_cnt <= x_end ? '0 : x_cnt + XW'(1);
            if (x_end)
                y_cnt <= y_end ? '0 : y_cnt + YW'(1);
        end
    end

    always_ff @(posedge pixel_clock_in) begin
        if (!pipe_reset_n)
            pix_valid <= 1'b0;
        else
            pix_valid <= accept;
    end

    always_ff @(posedge pixel_clock_in) begin
        if (accept) begin
            pix_rgb  <= '{red: red_data_in[9:2], green: green_data_in[9:2],
                          blue: blue_data_in[9:2]};   // keep the upper 8 bits
            pix_odd  <= x_cnt[0];
            pix_last <= x_end & y_end;
        end
        odd_dly  <= {odd_dly[0], pix_odd};
        last_dly <= {last_dly[0], pix_last};
        if (ycc_valid && !odd_dly[1])
            first_q <= ycc;
    end

    rgb_to_ycc i_rgb_to_ycc (
        .pixel_clock_in (pixel_clock_in),
        .pipe_reset_n   (pipe_reset_n),
        .rgb            (pix_rgb),
        .rgb_valid      (pix_valid),
        .ycc            (ycc),
        .ycc_valid      (ycc_valid)
    );

    // pair leaves in the cycle the odd pixel comes out of the converter
    assign pair.y0    = first_q.y;
    assign pair.y1    = ycc.y;
    assign pair.cb    = first_q.cb;
    assign pair.cr    = first_q.cr;
    assign pair.valid = ycc_valid & odd_dly[1];
    assign pair.last  = ycc_valid & odd_dly[1] & last_dly[1];

endmodule

// File: jisp/rgb_to_ycc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-point rgb to ycbcr, 2 cycle latency
// accepts a new pixel every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "jpeg_cfg.svh"

module rgb_to_ycc (
    input  logic             pixel_clock_in,
    input  logic             pipe_reset_n,
    input  jpeg_pkg::rgb24_t rgb,
    input  logic             rgb_valid,
    output jpeg_pkg::ycc_t   ycc,
    output logic             ycc_valid
);

    logic signed [17:0] sum_y;
    logic signed [17:0] sum_cb;
    logic signed [17:0] sum_cr;
    logic               sum_valid;

    // 18 bits hold +-255*256 with margin
    function automatic logic signed [17:0] mac(input logic [7:0] r, input logic [7:0] g,
                                               input logic [7:0] b, input int kr,
                                               input int kg, input int kb);
        int acc;
        acc = kr * int'(r) + kg * int'(g) + kb * int'(b);
        return acc[17:0];
    endfunction

    // drop the fraction, add offset, saturate to a byte
    function automatic logic [7:0] scale(input logic signed [17:0] sum, input int offset);
        int v;
        v = int'(sum >>> `JPEG_COEF_SHIFT) + offset;
        if (v < 0)
            return 8'd0;
        else if (v > 255)
            return 8'd255;
        return v[7:0];
    endfunction

    always_ff @(posedge pixel_clock_in) begin
        if (!pipe_reset_n) begin
            sum_valid <= 1'b0;
            ycc_valid <= 1'b0;
        end else begin
            sum_valid <= rgb_valid;
            ycc_valid <= sum_valid;
        end
    end

    always_ff @(posedge pixel_clock_in) begin
        // stage 1, products and sums
        sum_y  <= mac(rgb.red, rgb.green, rgb.blue,
                      `JPEG_Y_COEF_R, `JPEG_Y_COEF_G, `JPEG_Y_COEF_B);
        sum_cb <= mac(rgb.red, rgb.green, rgb.blue,
                      `JPEG_CB_COEF_R, `JPEG_CB_COEF_G, `JPEG_CB_COEF_B);
        sum_cr <= mac(rgb.red, rgb.green, rgb.blue,
                      `JPEG_CR_COEF_R, `JPEG_CR_COEF_G, `JPEG_CR_COEF_B);
        // stage 2
        ycc.y  <= scale(sum_y, 0);                 // luma needs no offset
        ycc.cb <= scale(sum_cb, `JPEG_CHROMA_OFFSET);
        ycc.cr <= scale(sum_cr, `JPEG_CHROMA_OFFSET);
    end

endmodule

// File: common/ycc_pair_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one 4:2:2 pixel pair, no back-pressure
// valid is a single-cycle strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface ycc_pair_if;

    logic [7:0] y0;     // luma of the even pixel
    logic [7:0] y1;     // luma of the odd pixel
    logic [7:0] cb;     // chroma taken from the even pixel
    logic [7:0] cr;
    logic       valid;
    logic       last;   // final pair of the frame, qualified by valid

    modport src (
        output y0, y1, cb, cr, valid, last
    );

    modport dst (
        input  y0, y1, cb, cr, valid, last
    );

endinterface

// File: common/jpeg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the capture front end
// colour samples are 8 bit, msb first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package jpeg_pkg;

    // capture fsm states in 3 bits
    typedef enum logic [2:0] {
        IDLE,
        RESET,
        WAIT_FOR_FRAME_START,
        COMPRESS,
        IMAGE_VALID
    } capture_state_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb24_t;

    typedef struct packed {
        logic [7:0] y;
        logic [7:0] cb;
        logic [7:0] cr;
    } ycc_t;

endpackage

// File: common/jpeg_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes, colour coefficients and quantizer shifts
// coefficients are scaled by 2^JPEG_COEF_SHIFT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef JPEG_CFG_SVH
`define JPEG_CFG_SVH

`define JPEG_SENSOR_X_SIZE   720
`define JPEG_SENSOR_Y_SIZE   720
`define JPEG_X_SIZE_W        $clog2(`JPEG_SENSOR_X_SIZE)
`define JPEG_Y_SIZE_W        $clog2(`JPEG_SENSOR_Y_SIZE)

`define JPEG_COEF_SHIFT      8
`define JPEG_CHROMA_OFFSET   128

`define JPEG_Y_COEF_R        77
`define JPEG_Y_COEF_G        150
`define JPEG_Y_COEF_B        29
`define JPEG_CB_COEF_R       (-43)
`define JPEG_CB_COEF_G       (-85)
`define JPEG_CB_COEF_B       128
`define JPEG_CR_COEF_R       128
`define JPEG_CR_COEF_G       (-107)
`define JPEG_CR_COEF_B       (-21)

`define JPEG_LUMA_SHIFT_0    3'd0
`define JPEG_LUMA_SHIFT_1    3'd1
`define JPEG_LUMA_SHIFT_2    3'd2
`define JPEG_LUMA_SHIFT_3    3'd3
`define JPEG_CHROMA_SHIFT_0  3'd1
`define JPEG_CHROMA_SHIFT_1  3'd2
`define JPEG_CHROMA_SHIFT_2  3'd3
`define JPEG_CHROMA_SHIFT_3  3'd4

`endif
